// ==== Bender.yml ====
package:
  name: fetch

sources:
  - common/fetch_pkg.sv
  - common/fetch_req_if.sv
  - bpu/branch_predictor.sv
  - design/fetch_csr.sv
  - design/pc_reg.sv
  - design/fetch_top.sv
  - target: test
    files:
      - sim/fetch_sva.sv
      - sim/fetch_tb.sv

// ==== bpu/branch_predictor.sv ====
module branch_predictor import fetch_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    // lookup port, combinational
    input  logic [addr_w-1:0] lookup_pc,
    output logic              pred_hit,
    output logic [addr_w-1:0] pred_target,

    // update port, one cycle strobe
    input  logic              upd_valid,
    input  logic [addr_w-1:0] upd_pc,
    input  logic [addr_w-1:0] upd_target,
    input  logic              upd_taken
);

    ////////////////////
    // table storage

    // valid bits and counters are control state
    logic [btb_entries-1:0] vld_q;
    logic [1:0]             ctr_q [btb_entries];
    // tags and targets, payload only
    logic [btb_tag_w-1:0]   tag_q [btb_entries];
    logic [addr_w-1:0]      tgt_q [btb_entries];

    logic [btb_idx_w-1:0]   rd_idx;
    logic [btb_tag_w-1:0]   rd_tag;
    logic [btb_idx_w-1:0]   wr_idx;
    logic [btb_tag_w-1:0]   wr_tag;
    logic                   wr_match;
    logic                   wr_en;
    logic [1:0]             wr_ctr;

    ////////////////////
    // lookup

    // index pc[5:2], tag pc[31:6]
    assign rd_idx = lookup_pc[btb_idx_w+1:2];
    assign rd_tag = lookup_pc[addr_w-1 -: btb_tag_w];

    // taken only on valid tag match with counter msb set
    assign pred_hit = vld_q[rd_idx]
                   && (tag_q[rd_idx] == rd_tag)
                   && ctr_q[rd_idx][1];
    assign pred_target = tgt_q[rd_idx];

    ////////////////////
    // update

    assign wr_idx   = upd_pc[btb_idx_w+1:2];
    assign wr_tag   = upd_pc[addr_w-1 -: btb_tag_w];
    assign wr_match = vld_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

    // not taken on a miss leaves the table alone
    assign wr_en = upd_valid && (upd_taken || wr_match);

    // saturating 2-bit counter step
    always_comb begin
        wr_ctr = ctr_q[wr_idx];
        if (upd_taken) begin
            if (wr_ctr != 2'd3) begin
                wr_ctr = wr_ctr + 2'd1;
            end
        end else if (wr_ctr != 2'd0) begin
            wr_ctr = wr_ctr - 2'd1;
        end
    end

    // valid and counters, cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
            for (int i = 0; i < btb_entries; i++) begin
                ctr_q[i] <= ctr_init;
            end
        end else if (wr_en) begin
            vld_q[wr_idx] <= 1'b1;
            ctr_q[wr_idx] <= wr_ctr;
        end
    end

    // tag and target written on taken updates
    always_ff @(posedge clk) begin
        if (upd_valid && upd_taken) begin
            tag_q[wr_idx] <= wr_tag;
            tgt_q[wr_idx] <= upd_target;
        end
    end

endmodule

// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    ////////////////////
    // address and reset

    // instruction address width
    localparam int unsigned addr_w = 32;

    // first fetch address after reset
    localparam logic [addr_w-1:0] reset_pc = 32'h1C00_0000;

    ////////////////////
    // exception codes

    localparam int unsigned ecode_w = 6;

    // no exception
    localparam logic [ecode_w-1:0] ecode_none = 6'h00;
    // interrupt shares code zero, told apart by the int flag
    localparam logic [ecode_w-1:0] ecode_int  = 6'h00;
    // fetch address error
    localparam logic [ecode_w-1:0] ecode_adef = 6'h08;

    ////////////////////
    // branch target buffer sizing

    localparam int unsigned btb_entries = 16;
    // index from pc[5:2]
    localparam int unsigned btb_idx_w   = 4;
    // tag from pc[31:6]
    localparam int unsigned btb_tag_w   = 26;

    // counters start weakly not taken
    localparam logic [1:0] ctr_init = 2'd1;

endpackage

// ==== common/fetch_req_if.sv ====
interface fetch_req_if import fetch_pkg::*; ();

    // fetch address offered to the memory side
    logic [addr_w-1:0] pc;
    // request valid, high from the first cycle after reset
    logic              valid;
    // consumer accepts the request
    logic              ready;

    // exception tags travelling with pc
    // misaligned fetch address
    logic              adef;
    // interrupt pending and enabled
    logic              int_pend;

    // producer side, the pc register
    modport src (
        output pc,
        output valid,
        output adef,
        output int_pend,
        input  ready
    );

    // consumer side, mapped to top level ports
    modport dst (
        input  pc,
        input  valid,
        input  adef,
        input  int_pend,
        output ready
    );

endinterface

// ==== design/fetch_csr.sv ====
module fetch_csr import fetch_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    // back end write port
    input  logic              csr_we,
    input  logic              csr_sel,
    input  logic [addr_w-1:0] csr_wdata,

    // fields steering the pc register
    output logic [addr_w-1:0] entry_pc,
    output logic              int_en
);

    ////////////////////
    // field select

    // sel 0 entry address, sel 1 interrupt enable
    logic we_entry;
    logic we_int_en;

    assign we_entry  = csr_we && !csr_sel;
    assign we_int_en = csr_we && csr_sel;

    logic [addr_w-1:0] entry_q;
    logic              int_en_q;

    ////////////////////
    // registers

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_q  <= reset_pc;
            int_en_q <= 1'b0;
        end else begin
            if (we_entry) begin
                // word aligned entry point
                entry_q <= {csr_wdata[addr_w-1:2], 2'b00};
            end
            if (we_int_en) begin
                // enable lives in bit 0
                int_en_q <= csr_wdata[0];
            end
        end
    end

    // visible to pc_reg from the next cycle
    assign entry_pc = entry_q;
    assign int_en   = int_en_q;

endmodule

// ==== design/fetch_top.sv ====
module fetch_top import fetch_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    // fetch consumer and pipeline control
    input  logic              ready,
    input  logic              pause,
    input  logic              exc_flush,
    input  logic              br_flush,
    input  logic [addr_w-1:0] br_target,
    input  logic              ext_int,

    // btb update strobe
    input  logic              upd_valid,
    input  logic [addr_w-1:0] upd_pc,
    input  logic [addr_w-1:0] upd_target,
    input  logic              upd_taken,

    // config write
    input  logic              csr_we,
    input  logic              csr_sel,
    input  logic [addr_w-1:0] csr_wdata,

    // fetch request out
    output logic [addr_w-1:0] fetch_pc,
    output logic              fetch_valid,
    output logic              fetch_adef,
    output logic              fetch_int_pend
);

    fetch_req_if req ();

    logic [addr_w-1:0] lookup_pc;
    logic              pred_hit;
    logic [addr_w-1:0] pred_target;
    logic [addr_w-1:0] entry_pc;
    logic              int_en;

    ////////////////////
    // instances

    pc_reg u_pc_reg (
        .clk         (clk),
        .rst         (rst),
        .req         (req.src),
        .pause       (pause),
        .exc_flush   (exc_flush),
        .br_flush    (br_flush),
        .br_target   (br_target),
        .entry_pc    (entry_pc),
        .int_en      (int_en),
        .ext_int     (ext_int),
        .pred_hit    (pred_hit),
        .pred_target (pred_target),
        .lookup_pc   (lookup_pc)
    );

    branch_predictor u_bpu (
        .clk         (clk),
        .rst         (rst),
        .lookup_pc   (lookup_pc),
        .pred_hit    (pred_hit),
        .pred_target (pred_target),
        .upd_valid   (upd_valid),
        .upd_pc      (upd_pc),
        .upd_target  (upd_target),
        .upd_taken   (upd_taken)
    );

    fetch_csr u_csr (
        .clk       (clk),
        .rst       (rst),
        .csr_we    (csr_we),
        .csr_sel   (csr_sel),
        .csr_wdata (csr_wdata),
        .entry_pc  (entry_pc),
        .int_en    (int_en)
    );

    ////////////////////
    // request to plain ports, consumer side

    assign fetch_pc       = req.pc;
    assign fetch_valid    = req.valid;
    assign fetch_adef     = req.adef;
    assign fetch_int_pend = req.int_pend;
    assign req.ready      = ready;

endmodule

// ==== design/pc_reg.sv ====
module pc_reg import fetch_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    fetch_req_if.src          req,

    // control from the back end
    input  logic              pause,
    input  logic              exc_flush,
    input  logic              br_flush,
    input  logic [addr_w-1:0] br_target,

    // configuration
    input  logic [addr_w-1:0] entry_pc,
    input  logic              int_en,
    input  logic              ext_int,

    // predictor lookup
    input  logic              pred_hit,
    input  logic [addr_w-1:0] pred_target,
    output logic [addr_w-1:0] lookup_pc
);

    logic [addr_w-1:0] pc_q;
    logic              valid_q;
    logic              adef_q;
    logic              int_pend_q;

    logic [addr_w-1:0] next_pc;
    logic              load;

    ////////////////////
    // next pc selection

    // priority order exc, pause, branch, back-pressure, btb, sequential
    always_comb begin
        load    = 1'b1;
        next_pc = pc_q + addr_w'(4);
        if (exc_flush) begin
            next_pc = entry_pc;
        end else if (pause) begin
            // branch redirect under pause is dropped
            load = 1'b0;
        end else if (br_flush) begin
            next_pc = br_target;
        end else if (!(valid_q && req.ready)) begin
            // no transfer this cycle, keep request stable
            load = 1'b0;
        end else if (pred_hit) begin
            next_pc = pred_target;
        end
    end

    ////////////////////
    // pc and tag registers

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q       <= reset_pc;
            valid_q    <= 1'b0;
            adef_q     <= 1'b0;
            int_pend_q <= 1'b0;
        end else begin
            // always requesting once out of reset
            valid_q <= 1'b1;
            if (load) begin
                pc_q       <= next_pc;
                // tags follow the pc being loaded
                adef_q     <= |next_pc[1:0];
                int_pend_q <= ext_int && int_en;
            end
        end
    end

    // outputs
    assign req.pc       = pc_q;
    assign req.valid    = valid_q;
    assign req.adef     = adef_q;
    assign req.int_pend = int_pend_q;

    // predictor sees the pc on offer
    assign lookup_pc = pc_q;

endmodule

// ==== fetch.f ====
common/fetch_pkg.sv
common/fetch_req_if.sv
bpu/branch_predictor.sv
design/fetch_csr.sv
design/pc_reg.sv
design/fetch_top.sv
sim/fetch_sva.sv
sim/fetch_tb.sv

// ==== sim/fetch_sva.sv ====
module fetch_sva import fetch_pkg::*; (
    input logic              clk,
    input logic              rst,
    input logic              ready,
    input logic              exc_flush,
    input logic              br_flush,
    input logic [addr_w-1:0] fetch_pc,
    input logic              fetch_valid,
    input logic              fetch_adef
);

    timeunit 1ns;
    timeprecision 1ps;

    // assertion failures seen so far
    int fails = 0;

    ////////////////////
    // reset

    // no request offered out of a reset cycle
    valid_low_in_reset: assert property (@(posedge clk) rst |=> !fetch_valid)
        else begin
            $error("fetch_valid high after a reset cycle");
            fails++;
        end

    ////////////////////
    // handshake and tags

    // stalled request holds its address unless flushed
    pc_stable_on_stall: assert property (@(posedge clk) disable iff (rst)
        fetch_valid && !ready && !exc_flush && !br_flush |=> $stable(fetch_pc))
        else begin
            $error("fetch_pc changed while the request was stalled");
            fails++;
        end

    // misaligned tag tracks the low pc bits
    adef_matches_pc: assert property (@(posedge clk) disable iff (rst)
        fetch_valid |-> fetch_adef == (|fetch_pc[1:0]))
        else begin
            $error("fetch_adef disagrees with the low bits of fetch_pc");
            fails++;
        end

endmodule

// ==== sim/fetch_tb.sv ====
module fetch_tb import fetch_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // one table row, inputs plus outputs expected after its edge
    typedef struct packed {
        logic [2:0]        test;
        logic              ready;
        logic              pause;
        logic              exc_flush;
        logic              br_flush;
        logic [addr_w-1:0] br_target;
        logic              ext_int;
        logic              upd_valid;
        logic              upd_taken;
        logic [addr_w-1:0] upd_pc;
        logic [addr_w-1:0] upd_target;
        logic              csr_we;
        logic              csr_sel;
        logic [addr_w-1:0] csr_wdata;
        logic [addr_w-1:0] exp_pc;
        logic              exp_valid;
        logic              exp_adef;
        logic              exp_int;
    } step_t;

    logic              clk = 1'b0;
    logic              rst;
    logic              ready, pause, exc_flush, br_flush, ext_int;
    logic [addr_w-1:0] br_target, upd_pc, upd_target, csr_wdata;
    logic              upd_valid, upd_taken, csr_we, csr_sel;
    logic [addr_w-1:0] fetch_pc;
    logic              fetch_valid, fetch_adef, fetch_int_pend;

    step_t  steps [128];
    step_t  cur;
    int     n_steps = 0;
    int     n_checks = 0;
    int     errors = 0;
    int     test_errors = 0;
    int     cycles = 0;
    int     limit = 1000;
    integer seed = 28052;
    string  names [1:5] = '{"sequential fetch", "btb train and decay", "branch redirect",
                            "exception entry", "exception tags"};

    // reference btb using the dut sizing
    logic                 m_vld [btb_entries];
    logic [btb_tag_w-1:0] m_tag [btb_entries];
    logic [addr_w-1:0]    m_tgt [btb_entries];
    logic [1:0]           m_ctr [btb_entries];

    fetch_top dut_i (.*);

    bind fetch_top fetch_sva sva_i (.*);

    ////////////////////
    // clock and watchdog

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: no end of the table after %0d cycles", limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    ////////////////////
    // table building

    task automatic add_steps(input int n, input bit rand_ready);
        int r;
        for (int i = 0; i < n; i++) begin
            if (rand_ready) begin
                r = $random(seed);
                cur.ready = r[0];
            end
            steps[n_steps] = cur;
            n_steps++;
            // flush, update and csr strobes last one step
            cur.exc_flush = 1'b0;
            cur.br_flush  = 1'b0;
            cur.upd_valid = 1'b0;
            cur.csr_we    = 1'b0;
        end
    endtask

    task automatic build_table();
        cur = '0;
        // straight line, then random consumer gaps
        cur.test = 3'd1;
        cur.ready = 1'b1;
        add_steps(6, 1'b0);
        add_steps(12, 1'b1);
        // jump to 0x1000, train 0x1008 toward 0x2000
        cur.test = 3'd2;
        cur.ready = 1'b1;
        cur.br_flush = 1'b1;
        cur.br_target = 32'h0000_1000;
        cur.upd_valid = 1'b1;
        cur.upd_taken = 1'b1;
        cur.upd_pc = 32'h0000_1008;
        cur.upd_target = 32'h0000_2000;
        add_steps(6, 1'b0);
        // weaken it again and walk the same loop
        cur.br_flush = 1'b1;
        cur.upd_valid = 1'b1;
        cur.upd_taken = 1'b0;
        add_steps(5, 1'b0);
        // redirect with ready low, then under pause
        cur.test = 3'd3;
        cur.ready = 1'b0;
        cur.br_flush = 1'b1;
        cur.br_target = 32'h0000_3000;
        add_steps(3, 1'b0);
        cur.ready = 1'b1;
        cur.pause = 1'b1;
        cur.br_flush = 1'b1;
        cur.br_target = 32'h0000_4000;
        add_steps(3, 1'b0);
        cur.pause = 1'b0;
        add_steps(2, 1'b0);
        // exception against pause and branch
        cur.test = 3'd4;
        cur.exc_flush = 1'b1;
        cur.pause = 1'b1;
        cur.br_flush = 1'b1;
        cur.br_target = 32'h0000_5000;
        add_steps(2, 1'b0);
        cur.pause = 1'b0;
        // misaligned entry address gets aligned on write
        cur.csr_we = 1'b1;
        cur.csr_sel = 1'b0;
        cur.csr_wdata = 32'h8000_0102;
        add_steps(2, 1'b0);
        cur.exc_flush = 1'b1;
        add_steps(3, 1'b0);
        // adef on odd target and int_pend gated by int_en
        cur.test = 3'd5;
        cur.br_flush = 1'b1;
        cur.br_target = 32'h0000_5002;
        add_steps(3, 1'b0);
        cur.br_flush = 1'b1;
        cur.br_target = 32'h0000_6000;
        cur.ext_int = 1'b1;
        add_steps(3, 1'b0);
        cur.csr_we = 1'b1;
        cur.csr_sel = 1'b1;
        cur.csr_wdata = 32'h0000_0001;
        add_steps(4, 1'b0);
        cur.ext_int = 1'b0;
        add_steps(3, 1'b0);
    endtask

    ////////////////////
    // reference model

    // index pc[5:2], tag pc[31:6]
    function automatic logic model_hit(input logic [addr_w-1:0] a);
        int i;
        i = a[5:2];
        return m_vld[i] && (m_tag[i] == a[31:6]) && m_ctr[i][1];
    endfunction

    task automatic model_update(input step_t s);
        int   i;
        logic match;
        i = s.upd_pc[5:2];
        match = m_vld[i] && (m_tag[i] == s.upd_pc[31:6]);
        if (s.upd_valid && s.upd_taken) begin
            m_vld[i] = 1'b1;
            m_tag[i] = s.upd_pc[31:6];
            m_tgt[i] = s.upd_target;
            if (m_ctr[i] != 2'd3) m_ctr[i] = m_ctr[i] + 2'd1;
        end else if (s.upd_valid && match && m_ctr[i] != 2'd0) begin
            m_ctr[i] = m_ctr[i] - 2'd1;
        end
    endtask

    task automatic fill_expected();
        logic [addr_w-1:0] pc;
        logic [addr_w-1:0] nxt;
        logic [addr_w-1:0] entry;
        logic              valid, adef, ipend, int_en, load;
        step_t             s;
        pc = reset_pc;
        entry = reset_pc;
        valid = 1'b0;
        adef = 1'b0;
        ipend = 1'b0;
        int_en = 1'b0;
        for (int i = 0; i < btb_entries; i++) begin
            m_vld[i] = 1'b0;
            m_ctr[i] = ctr_init;
        end
        for (int k = 0; k < n_steps; k++) begin
            s = steps[k];
            // exc, pause, branch, back-pressure, btb, pc plus 4
            load = 1'b1;
            nxt = pc + 32'd4;
            if (s.exc_flush) nxt = entry;
            else if (s.pause) load = 1'b0;
            else if (s.br_flush) nxt = s.br_target;
            else if (!(valid && s.ready)) load = 1'b0;
            else if (model_hit(pc)) nxt = m_tgt[pc[5:2]];
            if (load) begin
                pc = nxt;
                adef = |nxt[1:0];
                ipend = s.ext_int && int_en;
            end
            valid = 1'b1;
            // state seen once this step's edge has passed
            steps[k].exp_pc = pc;
            steps[k].exp_valid = valid;
            steps[k].exp_adef = adef;
            steps[k].exp_int = ipend;
            // table and csr change after this edge's lookup
            model_update(s);
            if (s.csr_we && !s.csr_sel) entry = {s.csr_wdata[31:2], 2'b00};
            if (s.csr_we && s.csr_sel) int_en = s.csr_wdata[0];
        end
    endtask

    ////////////////////
    // drive and compare

    task automatic drive_inputs(input step_t s);
        ready = s.ready;
        pause = s.pause;
        exc_flush = s.exc_flush;
        br_flush = s.br_flush;
        br_target = s.br_target;
        ext_int = s.ext_int;
        upd_valid = s.upd_valid;
        upd_taken = s.upd_taken;
        upd_pc = s.upd_pc;
        upd_target = s.upd_target;
        csr_we = s.csr_we;
        csr_sel = s.csr_sel;
        csr_wdata = s.csr_wdata;
    endtask

    task automatic check_outputs(input int k);
        step_t s;
        s = steps[k];
        n_checks += 4;
        if (fetch_pc !== s.exp_pc) begin
            $display("Mismatch step %0d fetch_pc: got %h expected %h", k, fetch_pc, s.exp_pc);
            test_errors++;
        end
        if (fetch_valid !== s.exp_valid) begin
            $display("Mismatch step %0d fetch_valid: got %h expected %h",
                     k, fetch_valid, s.exp_valid);
            test_errors++;
        end
        if (fetch_adef !== s.exp_adef) begin
            $display("Mismatch step %0d fetch_adef: got %h expected %h",
                     k, fetch_adef, s.exp_adef);
            test_errors++;
        end
        if (fetch_int_pend !== s.exp_int) begin
            $display("Mismatch step %0d fetch_int_pend: got %h expected %h",
                     k, fetch_int_pend, s.exp_int);
            test_errors++;
        end
    endtask

    ////////////////////
    // main sequence

    initial begin
        drive_inputs('0);
        rst = 1'b1;
        build_table();
        fill_expected();
        limit = 2 * n_steps + 50;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // no request yet before the first edge out of reset
        n_checks++;
        if (fetch_valid !== 1'b0) begin
            $display("Mismatch after reset fetch_valid: got %h expected %h",
                     fetch_valid, 1'b0);
            errors++;
        end
        for (int k = 0; k < n_steps; k++) begin
            drive_inputs(steps[k]);
            @(negedge clk);
            // outputs settled since the last rising edge
            check_outputs(k);
            if (k == n_steps - 1 || steps[k + 1].test != steps[k].test) begin
                $display("test %0d %s: %0d errors", steps[k].test, names[steps[k].test],
                         test_errors);
                errors += test_errors;
                test_errors = 0;
            end
        end
        $display("done: %0d steps, %0d checks, %0d errors, %0d assertion failures",
                 n_steps, n_checks, errors, dut_i.sva_i.fails);
        errors += dut_i.sva_i.fails;
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
